/* common/i2s_pkg.sv */
`default_nettype none

package i2s_pkg;

  // *************************************************************************
  // sample and frame geometry
  // *************************************************************************

  localparam int I2S_SAMPLE_WIDTH = 16;
  localparam int I2S_FRAME_WIDTH = 2 * I2S_SAMPLE_WIDTH;
  // up to 32 bclk periods per channel half.
  localparam int I2S_BIT_CNT_WIDTH = 6;

  // pad lanes.
  localparam int PAD_WIDTH = 4;
  localparam int PAD_BCLK = 0;
  localparam int PAD_ADC = 1;
  localparam int PAD_DAC = 2;
  localparam int PAD_LRCLK = 3;
  localparam logic [PAD_WIDTH-1:0] PAD_OE_CODEC = 4'b0100;
  localparam logic [PAD_WIDTH-1:0] PAD_OE_OVERRIDE = 4'b1111;

  // channel sequencer, same encoding on rx and tx.
  localparam int SEQ_STATE_WIDTH = 2;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_IDLE = 2'd0;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_FIRST = 2'd1;
  localparam logic [SEQ_STATE_WIDTH-1:0] SEQ_SECOND = 2'd2;

  // *************************************************************************
  // shared types
  // *************************************************************************

  typedef struct packed {
    logic bclk_rise;
    logic bclk_fall;
    logic lrclk_change;
    logic lrclk_fall;
    logic lrclk_level;
    logic adc_bit;
  } i2s_edges_t;

  // stream word or left/right pair.
  typedef union packed {
    logic [I2S_FRAME_WIDTH-1:0] word;
    struct packed {
      logic [I2S_SAMPLE_WIDTH-1:0] left;
      logic [I2S_SAMPLE_WIDTH-1:0] right;
    } ch;
  } stereo_frame_u;

endpackage

`default_nettype wire

/* logic/i2s_pad_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_pad_ctrl
  import i2s_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic [PAD_WIDTH-1:0] pad_in,
  input  logic                 alex_flag,
  input  logic [PAD_WIDTH-1:0] alex_data,
  input  logic                 dac_bit,
  output logic [PAD_WIDTH-1:0] pad_out,
  output logic [PAD_WIDTH-1:0] pad_oe,
  output i2s_edges_t           edges
);

  logic [2:0] bclk_sync;
  logic [2:0] lrclk_sync;
  logic [1:0] adc_sync;
  i2s_edges_t edges_next;

  // only the dac lane is ours unless the side controller takes over.
  always_comb
  begin
    pad_out = alex_data;
    pad_oe = PAD_OE_OVERRIDE;
    if (!alex_flag)
    begin
      pad_out[PAD_DAC] = dac_bit;
      pad_oe = PAD_OE_CODEC;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      bclk_sync <= '0;
      lrclk_sync <= '0;
      adc_sync <= '0;
    end
    else
    begin
      bclk_sync <= {bclk_sync[1:0], pad_in[PAD_BCLK]};
      lrclk_sync <= {lrclk_sync[1:0], pad_in[PAD_LRCLK]};
      adc_sync <= {adc_sync[0], pad_in[PAD_ADC]};
    end
  end

  // edges from the last two stages.
  always_comb
  begin
    edges_next.bclk_rise = bclk_sync[1] & ~bclk_sync[2];
    edges_next.bclk_fall = ~bclk_sync[1] & bclk_sync[2];
    edges_next.lrclk_change = lrclk_sync[1] ^ lrclk_sync[2];
    edges_next.lrclk_fall = ~lrclk_sync[1] & lrclk_sync[2];
    edges_next.lrclk_level = lrclk_sync[1];
    edges_next.adc_bit = adc_sync[1];
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      edges <= '0;
    else
      edges <= edges_next;
  end

endmodule

`default_nettype wire

/* i2s_rx/i2s_rx_deser.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_rx_deser
  import i2s_pkg::*;
(
  input  logic          aclk,
  input  logic          aresetn,
  input  i2s_edges_t    edges,
  input  logic          m_axis_tready,
  output stereo_frame_u m_axis_tdata,
  output logic          m_axis_tvalid
);

  logic [SEQ_STATE_WIDTH-1:0]   seq_state;
  logic [I2S_BIT_CNT_WIDTH-1:0] bit_cnt;
  logic [I2S_SAMPLE_WIDTH-1:0]  sample_sr;
  logic [I2S_SAMPLE_WIDTH-1:0]  left_hold;
  logic                         capture_en;
  logic                         half_close;
  logic                         frame_done;

  // counter saturates at one full sample.
  assign capture_en = edges.bclk_rise &&
                      (bit_cnt < I2S_BIT_CNT_WIDTH'(I2S_SAMPLE_WIDTH));

  // second rise after an lrclk change closes the previous channel.
  assign half_close = edges.bclk_rise && (seq_state == SEQ_SECOND);
  assign frame_done = half_close && !edges.lrclk_level;

  // *************************************************************************
  // channel sequencer and bit counter
  // *************************************************************************

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      seq_state <= SEQ_IDLE;
      bit_cnt <= '0;
    end
    else
    begin
      if (capture_en)
        bit_cnt <= bit_cnt + 1'b1;
      case (seq_state)
        SEQ_IDLE:
        begin
          if (edges.lrclk_change)
            seq_state <= SEQ_FIRST;
        end
        SEQ_FIRST:
        begin
          if (edges.bclk_rise)
          begin
            bit_cnt <= '0;
            seq_state <= SEQ_SECOND;
          end
        end
        SEQ_SECOND:
        begin
          if (edges.bclk_rise)
            seq_state <= SEQ_IDLE;
        end
        default: seq_state <= SEQ_IDLE;
      endcase
    end
  end

  // *************************************************************************
  // sample shift and frame assembly
  // *************************************************************************

  always_ff @(posedge aclk)
  begin
    if (capture_en)
      sample_sr <= {sample_sr[I2S_SAMPLE_WIDTH-2:0], edges.adc_bit};
    // lrclk high here means left just closed.
    if (half_close && edges.lrclk_level)
      left_hold <= sample_sr;
    if (frame_done)
    begin
      m_axis_tdata.ch.left <= left_hold;
      m_axis_tdata.ch.right <= sample_sr;
    end
  end

  // no stall, a new frame simply replaces the old one.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      m_axis_tvalid <= 1'b0;
    else if (frame_done)
      m_axis_tvalid <= 1'b1;
    else if (m_axis_tready)
      m_axis_tvalid <= 1'b0;
  end

endmodule

`default_nettype wire

/* i2s_tx/i2s_tx_ser.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_tx_ser
  import i2s_pkg::*;
(
  input  logic          aclk,
  input  logic          aresetn,
  input  i2s_edges_t    edges,
  input  stereo_frame_u s_axis_tdata,
  input  logic          s_axis_tvalid,
  output logic          s_axis_tready,
  output logic          dac_bit
);

  logic [SEQ_STATE_WIDTH-1:0]  seq_state;
  stereo_frame_u               frame_q;
  logic [I2S_SAMPLE_WIDTH-1:0] dac_sr;
  logic                        half_load;

  // one pulse per frame, at the start of the left channel.
  assign s_axis_tready = edges.lrclk_fall;

  // first fall after the first rise following an lrclk change.
  assign half_load = edges.bclk_fall && (seq_state == SEQ_SECOND);

  assign dac_bit = dac_sr[I2S_SAMPLE_WIDTH-1];

  // silence when nothing is offered.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      frame_q.word <= '0;
    else if (edges.lrclk_fall)
      frame_q.word <= s_axis_tvalid ? s_axis_tdata.word : '0;
  end

  // *************************************************************************
  // channel sequencer
  // *************************************************************************

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      seq_state <= SEQ_IDLE;
    else
    begin
      case (seq_state)
        SEQ_IDLE:
        begin
          if (edges.lrclk_change)
            seq_state <= SEQ_FIRST;
        end
        SEQ_FIRST:
        begin
          if (edges.bclk_rise)
            seq_state <= SEQ_SECOND;
        end
        SEQ_SECOND:
        begin
          if (edges.bclk_fall)
            seq_state <= SEQ_IDLE;
        end
        default: seq_state <= SEQ_IDLE;
      endcase
    end
  end

  // msb goes out first, stable before the 2nd rise.
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      dac_sr <= '0;
    else if (half_load)
      dac_sr <= edges.lrclk_level ? frame_q.ch.right : frame_q.ch.left;
    else if (edges.bclk_fall)
      dac_sr <= {dac_sr[I2S_SAMPLE_WIDTH-2:0], 1'b0};
  end

endmodule

`default_nettype wire

/* logic/i2s_codec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_codec_top
  import i2s_pkg::*;
(
  input  logic                       aclk,
  input  logic                       aresetn,

  // codec pads.
  input  logic [PAD_WIDTH-1:0]       pad_in,
  output logic [PAD_WIDTH-1:0]       pad_out,
  output logic [PAD_WIDTH-1:0]       pad_oe,

  // side controller override.
  input  logic                       alex_flag,
  input  logic [PAD_WIDTH-1:0]       alex_data,

  // adc stream.
  output logic [I2S_FRAME_WIDTH-1:0] m_axis_tdata,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,

  // dac stream.
  input  logic [I2S_FRAME_WIDTH-1:0] s_axis_tdata,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready
);

  i2s_edges_t edges;
  logic       dac_bit;

  i2s_pad_ctrl u_pad_ctrl (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .pad_in    (pad_in),
    .alex_flag (alex_flag),
    .alex_data (alex_data),
    .dac_bit   (dac_bit),
    .pad_out   (pad_out),
    .pad_oe    (pad_oe),
    .edges     (edges)
  );

  i2s_rx_deser u_rx_deser (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .edges         (edges),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid)
  );

  i2s_tx_ser u_tx_ser (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .edges         (edges),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .dac_bit       (dac_bit)
  );

endmodule

`default_nettype wire

/* dv/i2s_codec_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_codec_properties
  import i2s_pkg::*;
(
  input logic        aclk,
  input logic        aresetn,
  input logic [31:0] m_axis_tdata,
  input logic        m_axis_tvalid,
  input logic        m_axis_tready,
  input logic        frame_done,
  input logic        s_axis_tready,
  input logic        alex_flag,
  input logic [3:0]  pad_oe
);

  int fail_count = 0;

  // a newly completed frame may replace the one on offer.
  property tdata_held;
    @(posedge aclk) disable iff (!aresetn)
      (m_axis_tvalid && !m_axis_tready && !frame_done) |=> $stable(m_axis_tdata);
  endproperty

  property ready_single_pulse;
    @(posedge aclk) disable iff (!aresetn)
      s_axis_tready |=> !s_axis_tready;
  endproperty

  property codec_pad_dir;
    @(posedge aclk) !alex_flag |-> (pad_oe == 4'b0100);
  endproperty

  assert property (tdata_held)
    else
    begin
      fail_count++;
      $error("m_axis_tdata changed while the frame waited for tready");
    end
  assert property (ready_single_pulse)
    else
    begin
      fail_count++;
      $error("s_axis_tready high for two cycles in a row");
    end
  assert property (codec_pad_dir)
    else
    begin
      fail_count++;
      $error("pad_oe is not 0100 without override");
    end

endmodule

bind i2s_codec_top i2s_codec_properties u_i2s_codec_properties (
  .aclk          (aclk),
  .aresetn       (aresetn),
  .m_axis_tdata  (m_axis_tdata),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .frame_done    (u_rx_deser.frame_done),
  .s_axis_tready (s_axis_tready),
  .alex_flag     (alex_flag),
  .pad_oe        (pad_oe)
);

`default_nettype wire

/* dv/i2s_codec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module i2s_codec_tb
  import i2s_pkg::*;
();

  localparam int GOLDEN_WORDS = 16;
  localparam int ADC_BASE = 0;
  localparam int DAC_BASE = 6;
  localparam int PAD_BASE = 12;
  localparam int TEST_FRAMES = 6;
  localparam int PAD_WORDS = 4;
  localparam int RX_TIMEOUT = 2000;

  logic        aclk;
  logic        aresetn;
  logic [3:0]  pad_in;
  logic [3:0]  pad_out;
  logic [3:0]  pad_oe;
  logic        alex_flag;
  logic [3:0]  alex_data;
  logic [31:0] m_axis_tdata;
  logic        m_axis_tvalid;
  logic        m_axis_tready;
  logic [31:0] s_axis_tdata;
  logic        s_axis_tvalid;
  logic        s_axis_tready;

  logic [31:0] golden_mem [0:GOLDEN_WORDS-1];
  logic [31:0] rx_q [$];
  logic [31:0] rng_state;
  logic        rand_ready;
  int          error_count = 0;
  int          timeout_count = 0;
  int          fall_count = 0;
  int          tready_count = 0;

  i2s_codec_top u_i2s_codec_top (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .pad_in        (pad_in),
    .pad_out       (pad_out),
    .pad_oe        (pad_oe),
    .alex_flag     (alex_flag),
    .alex_data     (alex_data),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready)
  );

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // stream monitor.
  always @(posedge aclk)
  begin
    if (aresetn && m_axis_tvalid && m_axis_tready)
      rx_q.push_back(m_axis_tdata);
    if (aresetn && s_axis_tready)
      tready_count++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic tick();
    @(posedge aclk);
    #10;
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected)
    begin
      error_count++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  // *************************************************************************
  // i2s master model
  // *************************************************************************

  // one channel half of 32 bclk periods at 8 aclk cycles each.
  task automatic run_half(input logic level, input logic [15:0] sample,
                          output logic [15:0] dac_sample);
    int slot;
    int ph;
    dac_sample = '0;
    if (!level)
      fall_count++;
    for (slot = 0; slot < 32; slot++)
    begin
      for (ph = 0; ph < 8; ph++)
      begin
        tick();
        if (ph == 0)
        begin
          pad_in[PAD_BCLK] = 1'b0;
          if (slot == 0)
            pad_in[PAD_LRCLK] = level;
          // msb one slot after the lrclk change.
          pad_in[PAD_ADC] = 1'b0;
          if (slot >= 1 && slot <= 16)
            pad_in[PAD_ADC] = sample[16 - slot];
          if (rand_ready)
          begin
            rng_state = xorshift32(rng_state);
            m_axis_tready = rng_state[0];
          end
        end
        if (ph == 4)
          pad_in[PAD_BCLK] = 1'b1;
        // mid high phase.
        if (ph == 6 && slot >= 1 && slot <= 16)
          dac_sample[16 - slot] = pad_out[PAD_DAC];
      end
    end
  endtask

  // left half then right half with the dac offer or silence.
  task automatic run_frame(input logic [31:0] adc_word, input logic valid,
                           input logic [31:0] offer, input string what);
    logic [15:0] dac_left;
    logic [15:0] dac_right;
    s_axis_tvalid = valid;
    s_axis_tdata = offer;
    run_half(1'b0, adc_word[31:16], dac_left);
    if (valid)
    begin
      s_axis_tvalid = 1'b0;
      s_axis_tdata = ~offer;
    end
    run_half(1'b1, adc_word[15:0], dac_right);
    check_value({dac_left, dac_right}, valid ? offer : 32'h0, what);
  endtask

  task automatic wait_for_rx(input int count, input string what);
    int n;
    n = 0;
    while (rx_q.size() < count && n < RX_TIMEOUT)
    begin
      tick();
      n++;
    end
    if (rx_q.size() < count)
    begin
      timeout_count++;
      $display("timeout: the adc stream never delivered the %s", what);
    end
  endtask

  // *************************************************************************
  // test sequence
  // *************************************************************************

  initial
  begin
    int base;
    int i;
    int assert_fails;
    logic [15:0] dac_unused;
    aresetn = 1'b0;
    pad_in = '0;
    alex_flag = 1'b0;
    alex_data = '0;
    m_axis_tready = 1'b1;
    s_axis_tdata = '0;
    s_axis_tvalid = 1'b0;
    rand_ready = 1'b0;
    rng_state = 32'd65;
    $readmemh("dv/i2s_golden.hex", golden_mem);
    repeat (5) tick();
    aresetn = 1'b1;

    // idle bus after reset.
    repeat (8)
    begin
      tick();
      check_value({31'd0, m_axis_tvalid}, 32'd0, "m_axis_tvalid after reset");
      check_value({31'd0, s_axis_tready}, 32'd0, "s_axis_tready after reset");
      check_value({31'd0, pad_out[PAD_DAC]}, 32'd0, "dac pad after reset");
    end

    // right half first, so the first left half starts on an lrclk fall.
    run_half(1'b1, 16'h0000, dac_unused);

    // the first adc frame out predates the test.
    base = rx_q.size();
    for (i = 0; i < TEST_FRAMES; i++)
      run_frame(golden_mem[ADC_BASE + i], 1'b0, golden_mem[DAC_BASE + i],
                "dac idle during adc test");
    run_frame(32'h0, 1'b0, golden_mem[DAC_BASE], "dac idle during adc flush");
    wait_for_rx(base + TEST_FRAMES + 1, "captured adc frames");
    for (i = 0; i < TEST_FRAMES; i++)
      check_value(rx_q[base + 1 + i], golden_mem[ADC_BASE + i], $sformatf("adc frame %0d", i));

    // dac playback with random idle frames in between.
    rand_ready = 1'b1;
    for (i = 0; i < TEST_FRAMES; i++)
    begin
      rng_state = xorshift32(rng_state);
      if (rng_state[1])
        run_frame(32'h0, 1'b0, golden_mem[DAC_BASE + i], "dac gap frame");
      run_frame(32'h0, 1'b1, golden_mem[DAC_BASE + i], $sformatf("dac frame %0d", i));
    end
    run_frame(32'h0, 1'b0, golden_mem[DAC_BASE + TEST_FRAMES - 1], "dac idle after playback");

    // two frames complete while nobody reads.
    rand_ready = 1'b0;
    m_axis_tready = 1'b0;
    base = rx_q.size();
    run_frame(golden_mem[ADC_BASE + 2], 1'b0, golden_mem[DAC_BASE + 2],
              "dac idle during overwrite");
    run_frame(golden_mem[ADC_BASE + 3], 1'b0, golden_mem[DAC_BASE + 3],
              "dac idle during overwrite");
    run_half(1'b0, 16'h0000, dac_unused);
    check_value(32'(rx_q.size()), 32'(base), "frames taken while tready low");
    m_axis_tready = 1'b1;
    wait_for_rx(base + 1, "overwritten frame");
    repeat (4) tick();
    check_value(32'(rx_q.size()), 32'(base + 1), "frames taken after overwrite");
    check_value(rx_q[base], golden_mem[ADC_BASE + 3], "frame left after overwrite");

    // side controller override.
    alex_flag = 1'b1;
    for (i = 0; i < PAD_WORDS; i++)
    begin
      alex_data = golden_mem[PAD_BASE + i][3:0];
      tick();
      check_value({28'd0, pad_oe}, 32'h0000000f, "pad_oe in override");
      check_value({28'd0, pad_out}, {28'd0, golden_mem[PAD_BASE + i][3:0]},
                  "pad_out in override");
    end
    alex_flag = 1'b0;
    tick();
    check_value({28'd0, pad_oe}, 32'h00000004, "pad_oe after override");
    check_value({28'd0, pad_out & 4'b1011}, {28'd0, alex_data & 4'b1011},
                "pad_out lanes after override");

    check_value(32'(tready_count), 32'(fall_count), "s_axis_tready pulses");

    assert_fails = u_i2s_codec_top.u_i2s_codec_properties.fail_count;
    $display("errors: %0d, timeouts: %0d, assertion failures: %0d",
             error_count, timeout_count, assert_fails);
    if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/i2s_golden.hex */
// one 32-bit word per line; frames hold left in the upper 16 bits, right in the lower
// words 0-5 adc frames, 6-11 dac frames, 12-15 override pad words in the low 4 bits
a5a55a5a
1234abcd
8001fffe
00ff7f00
deadbeef
0f0f3c3c
cafe1357
80000001
13579bdf
fedcba98
55aa33cc
7fff8000
0000000f
00000005
0000000a
00000003

/* files.f */
common/i2s_pkg.sv
logic/i2s_pad_ctrl.sv
i2s_rx/i2s_rx_deser.sv
i2s_tx/i2s_tx_ser.sv
logic/i2s_codec_top.sv
dv/i2s_codec_properties.sv
dv/i2s_codec_tb.sv

/* Makefile */
# Verilator build and run for the I2S codec port testbench.

VERILATOR ?= verilator
TOP       ?= i2s_codec_tb
LOG       ?= sim.log
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
GOLDEN    ?= dv/i2s_golden.hex

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(GOLDEN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
